//--- compile.f
exu_pkg.sv
lsu_pkg.sv
exu_lsu_if.sv
exu_logic.sv
exu.sv
lsu.sv
exu_lsu_top.sv
exu_properties.sv
tb_exu_lsu_top.sv

//--- exu.sv
`timescale 1ns/100ps

module exu #(
  parameter int XLEN      = 32,
  parameter int REG_ADDRW = 5
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_pre_nop,
  input  logic                 i_pre_valid,
  output logic                 o_pre_ready,

  input  logic [XLEN-1:0]      i_idu_imm,
  input  logic [XLEN-1:0]      i_idu_rs1,
  input  logic [XLEN-1:0]      i_idu_rs2,
  input  logic [XLEN-1:0]      i_idu_pc,
  input  logic [REG_ADDRW-1:0] i_idu_rdid,
  input  logic                 i_idu_rdwen,
  input  exu_pkg::exu_sel_e    i_idu_exsrc,
  input  exu_pkg::exu_opt_e    i_idu_exopt,
  input  lsu_pkg::ls_func3_e   i_idu_lsfunc3,
  input  logic                 i_idu_lden,
  input  logic                 i_idu_sten,

  exu_lsu_if.exu_mp            post
);
  import exu_pkg::*;
  import lsu_pkg::*;

  logic                 pipe_wen;
  logic                 valid_r;

  logic [XLEN-1:0]      imm_r;
  logic [XLEN-1:0]      rs1_r;
  logic [XLEN-1:0]      rs2_r;
  logic [XLEN-1:0]      pc_r;
  logic [REG_ADDRW-1:0] rdid_r;
  logic                 rdwen_r;
  exu_sel_e             exsrc_r;
  exu_opt_e             exopt_r;
  ls_func3_e            lsfunc3_r;
  logic                 lden_r;
  logic                 sten_r;

  // free when empty or when the held item leaves this cycle
  assign o_pre_ready = !valid_r | post.ready;
  assign pipe_wen    = i_pre_valid & o_pre_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_r <= 1'b0;
    end else if (o_pre_ready) begin
      valid_r <= i_pre_valid;
    end
  end

  // a nop still travels as a valid item, computing 0 + 0 with no side effects
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      imm_r     <= '0;
      rs1_r     <= '0;
      rs2_r     <= '0;
      pc_r      <= '0;
      rdid_r    <= '0;
      rdwen_r   <= 1'b0;
      exsrc_r   <= SEL_REG;
      exopt_r   <= ADD;
      lsfunc3_r <= LB;
      lden_r    <= 1'b0;
      sten_r    <= 1'b0;
    end else if (pipe_wen) begin
      imm_r     <= i_pre_nop ? '0      : i_idu_imm;
      rs1_r     <= i_pre_nop ? '0      : i_idu_rs1;
      rs2_r     <= i_pre_nop ? '0      : i_idu_rs2;
      pc_r      <= i_idu_pc;
      rdid_r    <= i_pre_nop ? '0      : i_idu_rdid;
      rdwen_r   <= i_pre_nop ? 1'b0    : i_idu_rdwen;
      exsrc_r   <= i_pre_nop ? SEL_IMM : i_idu_exsrc;
      exopt_r   <= i_pre_nop ? ADD     : i_idu_exopt;
      lsfunc3_r <= i_idu_lsfunc3;
      lden_r    <= i_pre_nop ? 1'b0    : i_idu_lden;
      sten_r    <= i_pre_nop ? 1'b0    : i_idu_sten;
    end
  end

  // result is computed from the registered fields
  exu_logic #(
    .XLEN      (XLEN)
  ) u_exu_logic (
    .i_pc      (pc_r),
    .i_rs1     (rs1_r),
    .i_rs2     (rs2_r),
    .i_imm     (imm_r),
    .i_exsrc   (exsrc_r),
    .i_exopt   (exopt_r),
    .o_exu_res (post.res)
  );

  assign post.valid   = valid_r;
  assign post.rs2     = rs2_r;
  assign post.lsfunc3 = lsfunc3_r;
  assign post.lden    = lden_r;
  assign post.sten    = sten_r;
  assign post.rdid    = rdid_r;
  assign post.rdwen   = rdwen_r;

endmodule

//--- exu_logic.sv
`timescale 1ns/100ps

module exu_logic #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]   i_pc,
  input  logic [XLEN-1:0]   i_rs1,
  input  logic [XLEN-1:0]   i_rs2,
  input  logic [XLEN-1:0]   i_imm,
  input  exu_pkg::exu_sel_e i_exsrc,
  input  exu_pkg::exu_opt_e i_exopt,
  output logic [XLEN-1:0]   o_exu_res
);
  import exu_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [SHW-1:0]  shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  // operand selection
  always_comb begin
    case (i_exsrc)
      SEL_REG: begin
        op_a = i_rs1;
        op_b = i_rs2;
      end
      SEL_IMM: begin
        op_a = i_rs1;
        op_b = i_imm;
      end
      SEL_PCI: begin
        op_a = i_pc;
        op_b = i_imm;
      end
      SEL_PC4: begin
        op_a = i_pc;
        op_b = XLEN'(4);
      end
      default: begin
        op_a = i_rs1;
        op_b = i_rs2;
      end
    endcase
  end

  // only the low bits of b count as a shift amount
  assign shamt       = op_b[SHW-1:0];
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (i_exopt)
      ADD:     o_exu_res = op_a + op_b;
      SUB:     o_exu_res = op_a - op_b;
      AND:     o_exu_res = op_a & op_b;
      OR:      o_exu_res = op_a | op_b;
      XOR:     o_exu_res = op_a ^ op_b;
      SLL:     o_exu_res = op_a << shamt;
      SRL:     o_exu_res = op_a >> shamt;
      SRA:     o_exu_res = $unsigned($signed(op_a) >>> shamt);
      SLT:     o_exu_res = {{(XLEN-1){1'b0}}, lt_signed};
      SLTU:    o_exu_res = {{(XLEN-1){1'b0}}, lt_unsigned};
      PASSB:   o_exu_res = op_b;
      default: o_exu_res = '0;
    endcase
  end

endmodule

//--- exu_lsu_if.sv
`timescale 1ns/100ps

interface exu_lsu_if #(
  parameter int XLEN      = 32,
  parameter int REG_ADDRW = 5
);
  import lsu_pkg::*;

  // stage handshake
  logic                 valid;
  logic                 ready;

  // alu result doubles as the memory address
  logic [XLEN-1:0]      res;
  // store data
  logic [XLEN-1:0]      rs2;
  ls_func3_e            lsfunc3;
  logic                 lden;
  logic                 sten;

  // write-back destination
  logic [REG_ADDRW-1:0] rdid;
  logic                 rdwen;

  modport exu_mp (
    output valid, res, rs2, lsfunc3, lden, sten, rdid, rdwen,
    input  ready
  );

  modport lsu_mp (
    input  valid, res, rs2, lsfunc3, lden, sten, rdid, rdwen,
    output ready
  );

endinterface

//--- exu_lsu_top.sv
`timescale 1ns/100ps

module exu_lsu_top #(
  parameter int XLEN       = 32,
  parameter int REG_ADDRW  = 5,
  parameter int DMEM_WORDS = 64
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,

  // decode side
  input  logic                 i_pre_nop,
  input  logic                 i_pre_valid,
  output logic                 o_pre_ready,
  input  logic [XLEN-1:0]      i_idu_imm,
  input  logic [XLEN-1:0]      i_idu_rs1,
  input  logic [XLEN-1:0]      i_idu_rs2,
  input  logic [XLEN-1:0]      i_idu_pc,
  input  logic [REG_ADDRW-1:0] i_idu_rdid,
  input  logic                 i_idu_rdwen,
  input  exu_pkg::exu_sel_e    i_idu_exsrc,
  input  exu_pkg::exu_opt_e    i_idu_exopt,
  input  lsu_pkg::ls_func3_e   i_idu_lsfunc3,
  input  logic                 i_idu_lden,
  input  logic                 i_idu_sten,

  // write-back side
  input  logic                 i_wb_ready,
  output logic                 o_wb_valid,
  output logic [XLEN-1:0]      o_wb_data,
  output logic [REG_ADDRW-1:0] o_wb_rdid,
  output logic                 o_wb_rdwen
);

  exu_lsu_if #(
    .XLEN      (XLEN),
    .REG_ADDRW (REG_ADDRW)
  ) u_exu_lsu_if ();

  exu #(
    .XLEN          (XLEN),
    .REG_ADDRW     (REG_ADDRW)
  ) u_exu (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_pre_nop     (i_pre_nop),
    .i_pre_valid   (i_pre_valid),
    .o_pre_ready   (o_pre_ready),
    .i_idu_imm     (i_idu_imm),
    .i_idu_rs1     (i_idu_rs1),
    .i_idu_rs2     (i_idu_rs2),
    .i_idu_pc      (i_idu_pc),
    .i_idu_rdid    (i_idu_rdid),
    .i_idu_rdwen   (i_idu_rdwen),
    .i_idu_exsrc   (i_idu_exsrc),
    .i_idu_exopt   (i_idu_exopt),
    .i_idu_lsfunc3 (i_idu_lsfunc3),
    .i_idu_lden    (i_idu_lden),
    .i_idu_sten    (i_idu_sten),
    .post          (u_exu_lsu_if.exu_mp)
  );

  lsu #(
    .XLEN       (XLEN),
    .REG_ADDRW  (REG_ADDRW),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_lsu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .pre        (u_exu_lsu_if.lsu_mp),
    .i_wb_ready (i_wb_ready),
    .o_wb_valid (o_wb_valid),
    .o_wb_data  (o_wb_data),
    .o_wb_rdid  (o_wb_rdid),
    .o_wb_rdwen (o_wb_rdwen)
  );

endmodule

//--- exu_pkg.sv
package exu_pkg;

  // alu operation selected by decode
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLL   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    SLT   = 4'd8,
    SLTU  = 4'd9,
    // forwards operand b, used by lui
    PASSB = 4'd10
  } exu_opt_e;

  // operand sources for a and b
  typedef enum logic [1:0] {
    // rs1 and rs2
    SEL_REG = 2'd0,
    // rs1 and immediate
    SEL_IMM = 2'd1,
    // pc and immediate, auipc
    SEL_PCI = 2'd2,
    // pc and four, link address
    SEL_PC4 = 2'd3
  } exu_sel_e;

endpackage

//--- exu_properties.sv
`timescale 1ns/100ps

module exu_properties #(
  parameter int XLEN      = 32,
  parameter int REG_ADDRW = 5
) (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input logic                 i_wb_ready,
  input logic                 i_wb_valid,
  input logic [XLEN-1:0]      i_wb_data,
  input logic [REG_ADDRW-1:0] i_wb_rdid,
  input logic                 i_wb_rdwen,
  input logic                 i_if_valid,
  input logic                 i_if_ready
);
  int fail_count = 0;

  // a stalled write-back item keeps valid and payload
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_valid && !i_wb_ready |=> i_wb_valid && $stable(i_wb_data) && $stable(i_wb_rdid)
      && $stable(i_wb_rdwen))
  else begin
    fail_count++;
    $error("write-back output changed while stalled");
  end

  // execute-to-memory valid waits for its transfer
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_if_valid && !i_if_ready |=> i_if_valid)
  else begin
    fail_count++;
    $error("interface valid dropped before transfer");
  end

  assert property (@(posedge i_clk) !i_rst_n |-> !i_wb_valid)
  else begin
    fail_count++;
    $error("write-back valid high in reset");
  end

endmodule

bind exu_lsu_top exu_properties #(
  .XLEN       (XLEN),
  .REG_ADDRW  (REG_ADDRW)
) u_exu_properties (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_wb_ready (i_wb_ready),
  .i_wb_valid (o_wb_valid),
  .i_wb_data  (o_wb_data),
  .i_wb_rdid  (o_wb_rdid),
  .i_wb_rdwen (o_wb_rdwen),
  .i_if_valid (u_exu_lsu_if.valid),
  .i_if_ready (u_exu_lsu_if.ready)
);

//--- lsu.sv
`timescale 1ns/100ps

module lsu #(
  parameter int XLEN       = 32,
  parameter int REG_ADDRW  = 5,
  parameter int DMEM_WORDS = 64
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  exu_lsu_if.lsu_mp            pre,
  input  logic                 i_wb_ready,
  output logic                 o_wb_valid,
  output logic [XLEN-1:0]      o_wb_data,
  output logic [REG_ADDRW-1:0] o_wb_rdid,
  output logic                 o_wb_rdwen
);
  import lsu_pkg::*;

  localparam int LANES    = $bits(byte_en_t);
  localparam int ADDR_LSB = $clog2(LANES);
  localparam int WADDRW   = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]     dmem [DMEM_WORDS];

  logic                fire;
  logic                st_fire;
  logic [WADDRW-1:0]   waddr;
  logic [ADDR_LSB-1:0] boff;
  byte_en_t            ben;
  logic [XLEN-1:0]     wdata;
  logic [XLEN-1:0]     rword;
  logic [XLEN-1:0]     rshift;
  logic [XLEN-1:0]     ldata;

  assign pre.ready = !o_wb_valid | i_wb_ready;
  assign fire      = pre.valid & pre.ready;
  // a store is written once, at the edge that accepts it
  assign st_fire   = fire & pre.sten;

  // word index and byte offset come straight from the alu result
  assign waddr = pre.res[ADDR_LSB +: WADDRW];
  assign boff  = pre.res[ADDR_LSB-1:0];

  // store lanes, data replicated so any lane can pick its byte
  always_comb begin
    case (pre.lsfunc3)
      SB: begin
        ben   = byte_en_t'(1) << boff;
        wdata = {(XLEN/8){pre.rs2[7:0]}};
      end
      SH: begin
        ben   = byte_en_t'(3) << {boff[ADDR_LSB-1:1], 1'b0};
        wdata = {(XLEN/16){pre.rs2[15:0]}};
      end
      default: begin
        ben   = '1;
        wdata = pre.rs2;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (st_fire) begin
      for (int i = 0; i < LANES; i++) begin
        if (ben[i]) begin
          dmem[waddr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // asynchronous read, so a load right behind a store sees its data
  assign rword  = dmem[waddr];
  assign rshift = rword >> {boff, 3'b000};

  always_comb begin
    case (pre.lsfunc3)
      LB:      ldata = {{(XLEN-8){rshift[7]}}, rshift[7:0]};
      LBU:     ldata = {{(XLEN-8){1'b0}}, rshift[7:0]};
      LH:      ldata = {{(XLEN-16){rshift[15]}}, rshift[15:0]};
      LHU:     ldata = {{(XLEN-16){1'b0}}, rshift[15:0]};
      default: ldata = rword;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
    end else if (pre.ready) begin
      o_wb_valid <= pre.valid;
    end
  end

  // write-back register, held while downstream stalls
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_data  <= '0;
      o_wb_rdid  <= '0;
      o_wb_rdwen <= 1'b0;
    end else if (fire) begin
      o_wb_data  <= pre.lden ? ldata : pre.res;
      o_wb_rdid  <= pre.rdid;
      o_wb_rdwen <= pre.rdwen;
    end
  end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

  // funct3 access size, loads
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } ls_func3_e;

  // store sizes reuse the load codes 0 to 2
  localparam ls_func3_e SB = LB;
  localparam ls_func3_e SH = LH;
  localparam ls_func3_e SW = LW;

  // one enable per byte lane of a data word
  typedef logic [3:0] byte_en_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_exu_lsu_top -f compile.f -o sim_exu_lsu

# the log decides the result, so a stopped run still reaches the check
./obj_dir/sim_exu_lsu +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qxF "PASS: all tests" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- tb_exu_lsu_top.sv
`timescale 1ns/100ps

module tb_exu_lsu_top;
  import exu_pkg::*;
  import lsu_pkg::*;

  localparam int XLEN       = 32;
  localparam int REG_ADDRW  = 5;
  localparam int DMEM_WORDS = 64;
  localparam int WADDRW     = $clog2(DMEM_WORDS);
  // alu, pc, store/load, nop and back-pressure items
  localparam int N_ITEMS    = 22 + 4 + 45 + 4 + 24;
  localparam int MAX_CYCLES = N_ITEMS * 4 + 100;

  logic                 i_clk = 1'b0;
  logic                 i_rst_n, i_pre_nop, i_pre_valid, o_pre_ready;
  logic [XLEN-1:0]      i_idu_imm, i_idu_rs1, i_idu_rs2, i_idu_pc;
  logic [REG_ADDRW-1:0] i_idu_rdid;
  logic                 i_idu_rdwen, i_idu_lden, i_idu_sten;
  exu_sel_e             i_idu_exsrc;
  exu_opt_e             i_idu_exopt;
  ls_func3_e            i_idu_lsfunc3;
  logic                 i_wb_ready, o_wb_valid, o_wb_rdwen;
  logic [XLEN-1:0]      o_wb_data;
  logic [REG_ADDRW-1:0] o_wb_rdid;

  logic [XLEN-1:0]      exp_data[$];
  logic [REG_ADDRW-1:0] exp_rdid[$];
  logic                 exp_rdwen[$];
  logic [XLEN-1:0]      mem_model [DMEM_WORDS];
  logic [31:0]          rng_state = 32'h56ea;
  logic [31:0]          bp_state = 32'h56ea;
  logic                 bp_on = 1'b0;
  int                   val_errs = 0;
  int                   other_errs = 0;
  int                   cycles = 0;

  exu_lsu_top #(
    .XLEN       (XLEN),
    .REG_ADDRW  (REG_ADDRW),
    .DMEM_WORDS (DMEM_WORDS)
  ) exu_lsu_top_inst (.*);

  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input exu_sel_e src, input exu_opt_e op,
      input logic [XLEN-1:0] pc, rs1, rs2, imm);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = (src == SEL_PCI || src == SEL_PC4) ? pc : rs1;
    b = (src == SEL_REG) ? rs2 : (src == SEL_PC4) ? XLEN'(4) : imm;
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return $unsigned($signed(a) >>> b[4:0]);
      SLT:     return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
      SLTU:    return (a < b) ? XLEN'(1) : XLEN'(0);
      default: return b;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] load_model(input ls_func3_e f3, input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] w;
    w = mem_model[addr[2 +: WADDRW]] >> (8 * addr[1:0]);
    case (f3)
      LB:      return {{24{w[7]}}, w[7:0]};
      LBU:     return {24'd0, w[7:0]};
      LH:      return {{16{w[15]}}, w[15:0]};
      LHU:     return {16'd0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic store_model(input ls_func3_e f3, input logic [XLEN-1:0] addr,
      input logic [XLEN-1:0] data);
    int n;
    n = (f3 == SB) ? 1 : (f3 == SH) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      mem_model[addr[2 +: WADDRW]][8*(addr[1:0]+i) +: 8] = data[8*i +: 8];
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_rdid(input string name, input logic [REG_ADDRW-1:0] got, exp);
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      val_errs++;
    end
  endtask

  // drives one item, books its expected result and waits for its transfer
  task automatic send(input logic nop, input exu_sel_e src, input exu_opt_e op,
      input logic [XLEN-1:0] rs1, rs2, imm, input ls_func3_e f3, input logic lden, sten);
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      res;
    logic [REG_ADDRW-1:0] rdid;
    pc   = next_rand();
    rdid = REG_ADDRW'(next_rand());
    res  = alu_model(src, op, pc, rs1, rs2, imm);
    if (nop) begin
      exp_data.push_back('0);
      exp_rdid.push_back('0);
      exp_rdwen.push_back(1'b0);
    end else begin
      if (sten) begin
        store_model(f3, res, rs2);
      end
      exp_data.push_back(lden ? load_model(f3, res) : res);
      exp_rdid.push_back(rdid);
      exp_rdwen.push_back(!sten);
    end
    i_pre_nop     = nop;
    i_pre_valid   = 1'b1;
    i_idu_pc      = pc;
    i_idu_rs1     = rs1;
    i_idu_rs2     = rs2;
    i_idu_imm     = imm;
    i_idu_rdid    = rdid;
    i_idu_rdwen   = !sten;
    i_idu_exsrc   = src;
    i_idu_exopt   = op;
    i_idu_lsfunc3 = f3;
    i_idu_lden    = lden;
    i_idu_sten    = sten;
    @(negedge i_clk);
    while (!o_pre_ready) begin
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #5;
    i_pre_valid = 1'b0;
  endtask

  task automatic test_alu();
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o <= 10; o++) begin
        send(1'b0, exu_sel_e'(s), exu_opt_e'(o), next_rand(), next_rand(), next_rand(),
             LW, 1'b0, 1'b0);
      end
    end
    for (int i = 0; i < 2; i++) begin
      send(1'b0, SEL_PCI, ADD, next_rand(), next_rand(), next_rand(), LW, 1'b0, 1'b0);
      send(1'b0, SEL_PC4, ADD, next_rand(), next_rand(), next_rand(), LW, 1'b0, 1'b0);
    end
  endtask

  // full word, then a sized store into it, then every load size and offset
  task automatic test_store_load();
    logic [XLEN-1:0] base;
    ls_func3_e       st_f3;
    for (int k = 0; k < 3; k++) begin
      base  = XLEN'((8 + 5 * k) * 4);
      st_f3 = ls_func3_e'(2 - k);
      send(1'b0, SEL_IMM, ADD, base, next_rand(), '0, SW, 1'b0, 1'b1);
      send(1'b0, SEL_IMM, ADD, base, next_rand(), XLEN'(k * (3 - k)), st_f3, 1'b0, 1'b1);
      send(1'b0, SEL_IMM, ADD, base, next_rand(), '0, LW, 1'b1, 1'b0);
      for (int h = 0; h < 4; h += 2) begin
        send(1'b0, SEL_IMM, ADD, base, next_rand(), XLEN'(h), LH, 1'b1, 1'b0);
        send(1'b0, SEL_IMM, ADD, base, next_rand(), XLEN'(h), LHU, 1'b1, 1'b0);
      end
      for (int b = 0; b < 4; b++) begin
        send(1'b0, SEL_IMM, ADD, base, next_rand(), XLEN'(b), LB, 1'b1, 1'b0);
        send(1'b0, SEL_IMM, ADD, base, next_rand(), XLEN'(b), LBU, 1'b1, 1'b0);
      end
    end
  endtask

  task automatic test_nop();
    send(1'b1, SEL_REG, SUB, next_rand(), next_rand(), next_rand(), LW, 1'b0, 1'b0);
    send(1'b0, SEL_IMM, ADD, '0, next_rand(), '0, SW, 1'b0, 1'b1);
    // a nop clears its operands, so a leaked store would zero word 0
    send(1'b1, SEL_IMM, ADD, XLEN'(200), next_rand(), '0, SW, 1'b0, 1'b1);
    send(1'b0, SEL_IMM, ADD, '0, next_rand(), '0, LW, 1'b1, 1'b0);
  endtask

  task automatic test_backpressure();
    logic [XLEN-1:0] base;
    bp_on = 1'b1;
    for (int i = 0; i < 6; i++) begin
      base = XLEN'((16 + i) * 4);
      send(1'b0, exu_sel_e'(next_rand() % 2), exu_opt_e'(next_rand() % 11), next_rand(),
           next_rand(), next_rand(), LW, 1'b0, 1'b0);
      send(1'b0, SEL_IMM, ADD, base, next_rand(), '0, SW, 1'b0, 1'b1);
      send(1'b0, SEL_IMM, ADD, base, next_rand(), XLEN'(i % 4), SB, 1'b0, 1'b1);
      send(1'b0, SEL_IMM, ADD, base, next_rand(), '0, LW, 1'b1, 1'b0);
    end
    bp_on = 1'b0;
  endtask

  // bp_on is sampled at the edge so the main process may change it after the edge
  always @(posedge i_clk) begin : ready_driver
    logic bp_now;
    bp_now = bp_on;
    #5;
    if (bp_now) begin
      bp_state   = xorshift32(bp_state);
      i_wb_ready = bp_state[7];
    end else begin
      i_wb_ready = 1'b1;
    end
  end

  // write-back inputs are stable at the falling edge, the transfer follows at the next rise
  always @(negedge i_clk) begin
    if (i_rst_n && o_wb_valid && i_wb_ready) begin
      if (exp_data.size() == 0) begin
        $display("unexpected write-back item with data %h at %0t", o_wb_data, $time);
        other_errs++;
      end else begin
        check_data("o_wb_data", o_wb_data, exp_data.pop_front());
        check_rdid("o_wb_rdid", o_wb_rdid, exp_rdid.pop_front());
        check_bit("o_wb_rdwen", o_wb_rdwen, exp_rdwen.pop_front());
      end
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d items missing", cycles, exp_data.size());
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    {i_rst_n, i_pre_nop, i_pre_valid, i_idu_rdwen, i_idu_lden, i_idu_sten} = '0;
    {i_idu_imm, i_idu_rs1, i_idu_rs2, i_idu_pc, i_idu_rdid} = '0;
    i_idu_exsrc   = SEL_REG;
    i_idu_exopt   = ADD;
    i_idu_lsfunc3 = LW;
    i_wb_ready    = 1'b1;
    repeat (10) @(posedge i_clk);
    #5;
    check_bit("o_wb_valid", o_wb_valid, 1'b0);
    check_bit("o_wb_rdwen", o_wb_rdwen, 1'b0);
    check_bit("o_pre_ready", o_pre_ready, 1'b1);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check_bit("o_wb_valid", o_wb_valid, 1'b0);
    check_bit("o_wb_rdwen", o_wb_rdwen, 1'b0);
    check_bit("o_pre_ready", o_pre_ready, 1'b1);
    @(posedge i_clk);
    #5;
    test_alu();
    test_store_load();
    test_nop();
    test_backpressure();
    while (exp_data.size() != 0) begin
      @(negedge i_clk);
    end
    // a few idle cycles to catch extra items
    repeat (4) @(posedge i_clk);
    other_errs += exu_lsu_top_inst.u_exu_properties.fail_count;
    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
